//--- tb.f
+incdir+test
design/uart_bus_pkg.sv
design/uart_cfg_pkg.sv
design/uart_apb_bridge.sv
design/uart_regs.sv
design/uart_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_subsys.sv
test/tb_uart_subsys.sv

//--- Makefile
SIM := obj_dir/Vtb_uart_subsys

.PHONY: all run clean

all: run

$(SIM): tb.f $(wildcard design/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tb_uart_subsys -Mdir obj_dir

run: $(SIM)
	./$(SIM) > sim.log 2>&1; rc=$$?; cat sim.log; \
	test $$rc -eq 0 && ! grep -q "TESTBENCH FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- test/tb_uart_tasks.svh
// UART testbench tasks
`ifndef TB_UART_TASKS_SVH
`define TB_UART_TASKS_SVH

// one request strobe, then wait for the response pulse with a bound
task automatic bus_access(input logic wr, input uart_bus_pkg::reg_addr_t addr,
                          input uart_bus_pkg::word_t wdata,
                          output uart_bus_pkg::word_t rdata, output logic err);
    int waited;
    @(posedge clk_i);
    #2;
    req_valid_i   = 1'b1;
    req_i.write   = wr;
    req_i.addr    = addr;
    req_i.wdata   = wdata;
    @(posedge clk_i);
    #2;
    req_valid_i = 1'b0;
    waited      = 0;
    @(negedge clk_i);
    while (!rsp_valid_o && waited < 8) begin
        @(negedge clk_i);
        waited++;
    end
    if (!rsp_valid_o) begin
        error_count++;
        $display("no bus response arrived for the request at %0t", $time);
    end
    rdata = rsp_rdata_o;
    err   = rsp_err_o;
endtask

// start bit, data LSB first, stop bit, then one idle bit time
task automatic send_frame(input uart_cfg_pkg::byte_t data, input logic stop_bit);
    logic [9:0] frame;
    frame = {stop_bit, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
        @(posedge clk_i);
        #2;
        rx_i = frame[i];
        repeat (uart_cfg_pkg::CLKS_PER_BIT - 1) @(posedge clk_i);
    end
    @(posedge clk_i);
    #2;
    rx_i = 1'b1;
    repeat (uart_cfg_pkg::CLKS_PER_BIT - 1) @(posedge clk_i);
endtask

// waits for a start bit and samples every bit near its middle
task automatic check_tx_frame();
    uart_cfg_pkg::byte_t data;
    uart_cfg_pkg::byte_t expected;
    @(negedge tx_o);
    repeat (uart_cfg_pkg::CLKS_PER_BIT / 2) @(negedge clk_i);
    check_value("tx_o start bit", 32'h0, {31'h0, tx_o});
    for (int i = 0; i < 8; i++) begin
        repeat (uart_cfg_pkg::CLKS_PER_BIT) @(negedge clk_i);
        data[i] = tx_o;
    end
    repeat (uart_cfg_pkg::CLKS_PER_BIT) @(negedge clk_i);
    check_value("tx_o stop bit", 32'h1, {31'h0, tx_o});
    if (exp_tx.size() == 0) begin
        error_count++;
        $display("a frame started on tx_o at %0t although none was expected", $time);
    end else begin
        expected = exp_tx.pop_front();
        check_value("tx_o data", {24'h0, expected}, {24'h0, data});
    end
endtask

`endif

//--- test/tb_uart_subsys.sv
// UART subsystem testbench
`timescale 1ns/100ps

module tb_uart_subsys;

    localparam int NUM_FRAMES     = 19;
    // ten bits per frame, the rest covers bus accesses, CTS hold windows and idle gaps
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 10 * uart_cfg_pkg::CLKS_PER_BIT + 1480;
    localparam int HOLD_CYCLES    = 2 * 10 * uart_cfg_pkg::CLKS_PER_BIT;

    logic                   clk_i;
    logic                   rst_n_i;
    logic                   req_valid_i;
    uart_bus_pkg::bus_req_t req_i;
    logic                   rx_i;
    logic                   cts_i;
    logic                   rsp_valid_o;
    uart_bus_pkg::word_t    rsp_rdata_o;
    logic                   rsp_err_o;
    logic                   tx_o;
    logic                   rts_o;
    logic                   irq_o;

    integer                 seed = 5055;
    int                     error_count = 0;
    int                     cycle_count = 0;
    uart_cfg_pkg::byte_t    exp_tx[$];
    uart_cfg_pkg::byte_t    exp_rx[$];

    uart_subsys dut_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .rx_i        (rx_i),
        .cts_i       (cts_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o),
        .tx_o        (tx_o),
        .rts_o       (rts_o),
        .irq_o       (irq_o)
    );

    function automatic void check_value(input string name, input uart_bus_pkg::word_t expected,
                                        input uart_bus_pkg::word_t actual);
        assert (actual === expected) else begin
            error_count++;
            $display("[FAIL] %0t %s expected %0h got %0h", $time, name, expected, actual);
        end
    endfunction

    function automatic uart_cfg_pkg::byte_t next_byte();
        uart_bus_pkg::word_t r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic uart_bus_pkg::word_t expected_status(input logic tx_full,
            input logic tx_empty, input logic rx_empty, input logic rx_full, input logic ovr);
        uart_bus_pkg::word_t w;
        w                              = '0;
        w[uart_cfg_pkg::ST_TX_FULL]    = tx_full;
        w[uart_cfg_pkg::ST_TX_EMPTY]   = tx_empty;
        w[uart_cfg_pkg::ST_RX_EMPTY]   = rx_empty;
        w[uart_cfg_pkg::ST_RX_FULL]    = rx_full;
        w[uart_cfg_pkg::ST_RX_OVERRUN] = ovr;
        return w;
    endfunction

    `include "tb_uart_tasks.svh"

    task automatic write_reg(input uart_bus_pkg::reg_addr_t addr,
                             input uart_bus_pkg::word_t wdata, input logic exp_err);
        uart_bus_pkg::word_t rdata;
        logic                err;
        bus_access(1'b1, addr, wdata, rdata, err);
        check_value("rsp_err_o", {31'h0, exp_err}, {31'h0, err});
    endtask

    task automatic read_reg(input uart_bus_pkg::reg_addr_t addr,
                            input uart_bus_pkg::word_t exp_data, input logic exp_err);
        uart_bus_pkg::word_t rdata;
        logic                err;
        bus_access(1'b0, addr, '0, rdata, err);
        check_value("rsp_err_o", {31'h0, exp_err}, {31'h0, err});
        if (!exp_err) begin
            check_value("rsp_rdata_o", exp_data, rdata);
        end
    endtask

    task automatic send_tx_byte();
        uart_cfg_pkg::byte_t b;
        b = next_byte();
        exp_tx.push_back(b);
        write_reg(uart_bus_pkg::ADDR_DATA, {24'h0, b}, 1'b0);
    endtask

    task automatic receive_byte();
        uart_cfg_pkg::byte_t b;
        b = next_byte();
        exp_rx.push_back(b);
        send_frame(b, 1'b1);
    endtask

    // the monitor pops each byte at the stop bit, so an empty queue means the line is done
    task automatic wait_tx_drained();
        while (exp_tx.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (uart_cfg_pkg::CLKS_PER_BIT) @(posedge clk_i);
    endtask

    task automatic set_cts(input logic value);
        @(posedge clk_i);
        #2;
        cts_i = value;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, a test never finished", cycle_count);
            $display("closing report: %0d errors", error_count);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    a_rsp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(req_valid_i, 3) |-> rsp_valid_o)
        else begin
            error_count++;
            $display("[FAIL] %0t rsp_valid_o expected 1 got 0", $time);
        end

    a_rsp_has_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_o |-> $past(req_valid_i, 3))
        else begin
            error_count++;
            $display("[FAIL] %0t rsp_valid_o expected 0 got 1", $time);
        end

    // a full RX FIFO always holds data
    a_rts_with_irq: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rts_o |-> irq_o)
        else begin
            error_count++;
            $display("rts_o is high at %0t while irq_o is low", $time);
        end

    initial begin
        @(posedge rst_n_i);
        forever check_tx_frame();
    end

    initial begin
        rst_n_i     = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rx_i        = 1'b1;
        cts_i       = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        rst_n_i = 1'b1;
        @(negedge clk_i);
        check_value("tx_o", 32'h1, {31'h0, tx_o});
        check_value("rsp_valid_o", 32'h0, {31'h0, rsp_valid_o});
        check_value("irq_o", 32'h0, {31'h0, irq_o});
        check_value("rts_o", 32'h0, {31'h0, rts_o});
        read_reg(uart_bus_pkg::ADDR_STATUS, expected_status(0, 1, 1, 0, 0), 1'b0);
        read_reg(4'h8, '0, 1'b1);
        write_reg(4'hc, '0, 1'b1);

        repeat (4) send_tx_byte();
        wait_tx_drained();

        // CTS raised while a frame is on the line holds back the second one
        repeat (2) send_tx_byte();
        wait (tx_o == 1'b0);
        set_cts(1'b1);
        repeat (HOLD_CYCLES) @(posedge clk_i);
        check_value("tx frames pending", 32'd1, exp_tx.size());
        set_cts(1'b0);
        wait_tx_drained();

        set_cts(1'b1);
        repeat (uart_cfg_pkg::FIFO_DEPTH) send_tx_byte();
        read_reg(uart_bus_pkg::ADDR_STATUS, expected_status(1, 0, 1, 0, 0), 1'b0);
        write_reg(uart_bus_pkg::ADDR_DATA, {24'h0, next_byte()}, 1'b1);
        repeat (HOLD_CYCLES) @(posedge clk_i);
        check_value("tx frames pending", uart_cfg_pkg::FIFO_DEPTH, exp_tx.size());
        set_cts(1'b0);
        wait_tx_drained();
        read_reg(uart_bus_pkg::ADDR_STATUS, expected_status(0, 1, 1, 0, 0), 1'b0);

        // a frame with a low stop bit sits between good ones
        receive_byte();
        send_frame(next_byte(), 1'b0);
        repeat (2) receive_byte();
        check_value("irq_o", 32'h1, {31'h0, irq_o});
        repeat (3) read_reg(uart_bus_pkg::ADDR_DATA, {24'h0, exp_rx.pop_front()}, 1'b0);
        check_value("irq_o", 32'h0, {31'h0, irq_o});
        read_reg(uart_bus_pkg::ADDR_DATA, '0, 1'b1);

        repeat (uart_cfg_pkg::FIFO_DEPTH) receive_byte();
        check_value("rts_o", 32'h1, {31'h0, rts_o});
        read_reg(uart_bus_pkg::ADDR_STATUS, expected_status(0, 1, 0, 1, 0), 1'b0);
        send_frame(next_byte(), 1'b1);
        read_reg(uart_bus_pkg::ADDR_STATUS, expected_status(0, 1, 0, 1, 1), 1'b0);
        read_reg(uart_bus_pkg::ADDR_STATUS, expected_status(0, 1, 0, 1, 0), 1'b0);
        repeat (uart_cfg_pkg::FIFO_DEPTH) begin
            read_reg(uart_bus_pkg::ADDR_DATA, {24'h0, exp_rx.pop_front()}, 1'b0);
        end
        check_value("rts_o", 32'h0, {31'h0, rts_o});
        check_value("irq_o", 32'h0, {31'h0, irq_o});

        $display("closing report: %0d errors after %0d cycles", error_count, cycle_count);
        if (error_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- design/uart_subsys.sv
// UART subsystem top level
`timescale 1ns/100ps

module uart_subsys (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  uart_bus_pkg::bus_req_t req_i,
    input  logic                   rx_i,
    input  logic                   cts_i,
    output logic                   rsp_valid_o,
    output uart_bus_pkg::word_t    rsp_rdata_o,
    output logic                   rsp_err_o,
    output logic                   tx_o,
    output logic                   rts_o,
    output logic                   irq_o
);

    uart_bus_pkg::apb_req_t apb_req;
    uart_bus_pkg::apb_rsp_t apb_rsp;
    logic                   tx_push;
    logic                   tx_pop;
    logic                   tx_full;
    logic                   tx_empty;
    uart_cfg_pkg::byte_t    tx_wdata;
    uart_cfg_pkg::byte_t    tx_head;
    logic                   rx_valid;
    logic                   rx_pop;
    logic                   rx_full;
    logic                   rx_empty;
    uart_cfg_pkg::byte_t    rx_byte;
    uart_cfg_pkg::byte_t    rx_head;

    uart_apb_bridge bridge_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .apb_rsp_i   (apb_rsp),
        .apb_req_o   (apb_req),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_err_o   (rsp_err_o)
    );

    uart_regs regs_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .apb_req_i  (apb_req),
        .tx_full_i  (tx_full),
        .tx_empty_i (tx_empty),
        .rx_empty_i (rx_empty),
        .rx_full_i  (rx_full),
        .rx_data_i  (rx_head),
        .rx_valid_i (rx_valid),
        .apb_rsp_o  (apb_rsp),
        .tx_push_o  (tx_push),
        .tx_data_o  (tx_wdata),
        .rx_pop_o   (rx_pop)
    );

    uart_fifo tx_fifo_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (tx_push),
        .data_i  (tx_wdata),
        .pop_i   (tx_pop),
        .data_o  (tx_head),
        .full_o  (tx_full),
        .empty_o (tx_empty)
    );

    // a byte that arrives while the RX FIFO is full is lost
    uart_fifo rx_fifo_i (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .push_i  (rx_valid && !rx_full),
        .data_i  (rx_byte),
        .pop_i   (rx_pop),
        .data_o  (rx_head),
        .full_o  (rx_full),
        .empty_o (rx_empty)
    );

    uart_tx tx_i (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .fifo_empty_i (tx_empty),
        .fifo_data_i  (tx_head),
        .cts_i        (cts_i),
        .fifo_pop_o   (tx_pop),
        .tx_o         (tx_o)
    );

    uart_rx rx_i_inst (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rx_i       (rx_i),
        .rx_valid_o (rx_valid),
        .rx_data_o  (rx_byte)
    );

    assign rts_o = rx_full;
    assign irq_o = !rx_empty;

endmodule

//--- design/uart_rx.sv
// UART receiver
`timescale 1ns/100ps

module uart_rx (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                rx_i,
    output logic                rx_valid_o,
    output uart_cfg_pkg::byte_t rx_data_o
);

    uart_cfg_pkg::rx_state_e                       state_q;
    logic [$clog2(uart_cfg_pkg::CLKS_PER_BIT)-1:0] baud_cnt_q;
    logic [2:0]                                    bit_idx_q;
    logic                                          rx_meta_q;
    logic                                          rx_sync_q;
    logic                                          half_bit;
    logic                                          full_bit;

    assign half_bit = (baud_cnt_q == $bits(baud_cnt_q)'(uart_cfg_pkg::CLKS_PER_BIT / 2 - 1));
    assign full_bit = (baud_cnt_q == $bits(baud_cnt_q)'(uart_cfg_pkg::CLKS_PER_BIT - 1));

    // the line idles high, so the synchronizer resets to one
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rx_meta_q <= 1'b1;
            rx_sync_q <= 1'b1;
        end else begin
            rx_meta_q <= rx_i;
            rx_sync_q <= rx_meta_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= uart_cfg_pkg::RX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
            rx_valid_o <= 1'b0;
        end else begin
            rx_valid_o <= 1'b0;
            baud_cnt_q <= full_bit ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                uart_cfg_pkg::RX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (!rx_sync_q) begin
                        state_q <= uart_cfg_pkg::RX_START;
                    end
                end
                uart_cfg_pkg::RX_START: begin
                    // a start bit that is gone by mid-bit was only a glitch
                    if (half_bit) begin
                        baud_cnt_q <= '0;
                        bit_idx_q  <= '0;
                        state_q    <= rx_sync_q ? uart_cfg_pkg::RX_IDLE : uart_cfg_pkg::RX_DATA;
                    end
                end
                uart_cfg_pkg::RX_DATA: begin
                    if (full_bit) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= uart_cfg_pkg::RX_STOP;
                        end
                    end
                end
                default: begin
                    // frames with a low stop bit are dropped here
                    if (full_bit) begin
                        rx_valid_o <= rx_sync_q;
                        state_q    <= uart_cfg_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == uart_cfg_pkg::RX_DATA && full_bit) begin
            rx_data_o <= {rx_sync_q, rx_data_o[7:1]};
        end
    end

endmodule

//--- design/uart_tx.sv
// UART transmitter
`timescale 1ns/100ps

module uart_tx (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                fifo_empty_i,
    input  uart_cfg_pkg::byte_t fifo_data_i,
    input  logic                cts_i,
    output logic                fifo_pop_o,
    output logic                tx_o
);

    uart_cfg_pkg::tx_state_e                       state_q;
    logic [$clog2(uart_cfg_pkg::CLKS_PER_BIT)-1:0] baud_cnt_q;
    logic [2:0]                                    bit_idx_q;
    uart_cfg_pkg::byte_t                           shift_q;
    logic                                          bit_end;

    assign bit_end = (baud_cnt_q == $bits(baud_cnt_q)'(uart_cfg_pkg::CLKS_PER_BIT - 1));

    // CTS is active low and only gates the start of a new frame
    assign fifo_pop_o = (state_q == uart_cfg_pkg::TX_IDLE) && !fifo_empty_i && !cts_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q    <= uart_cfg_pkg::TX_IDLE;
            baud_cnt_q <= '0;
            bit_idx_q  <= '0;
        end else begin
            baud_cnt_q <= bit_end ? '0 : baud_cnt_q + 1'b1;
            case (state_q)
                uart_cfg_pkg::TX_IDLE: begin
                    baud_cnt_q <= '0;
                    if (fifo_pop_o) begin
                        state_q <= uart_cfg_pkg::TX_START;
                    end
                end
                uart_cfg_pkg::TX_START: begin
                    if (bit_end) begin
                        state_q   <= uart_cfg_pkg::TX_DATA;
                        bit_idx_q <= '0;
                    end
                end
                uart_cfg_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_idx_q <= bit_idx_q + 1'b1;
                        if (bit_idx_q == 3'd7) begin
                            state_q <= uart_cfg_pkg::TX_STOP;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        state_q <= uart_cfg_pkg::TX_IDLE;
                    end
                end
            endcase
        end
    end

    // data goes out LSB first
    always_ff @(posedge clk_i) begin
        if (fifo_pop_o) begin
            shift_q <= fifo_data_i;
        end else if (state_q == uart_cfg_pkg::TX_DATA && bit_end) begin
            shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    always_comb begin
        case (state_q)
            uart_cfg_pkg::TX_START: tx_o = 1'b0;
            uart_cfg_pkg::TX_DATA:  tx_o = shift_q[0];
            default:                tx_o = 1'b1;
        endcase
    end

endmodule

//--- design/uart_fifo.sv
// Synchronous byte FIFO
`timescale 1ns/100ps

module uart_fifo (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                push_i,
    input  uart_cfg_pkg::byte_t data_i,
    input  logic                pop_i,
    output uart_cfg_pkg::byte_t data_o,
    output logic                full_o,
    output logic                empty_o
);

    uart_cfg_pkg::byte_t mem_q [uart_cfg_pkg::FIFO_DEPTH];
    logic [$clog2(uart_cfg_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(uart_cfg_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;
    uart_cfg_pkg::fifo_cnt_t count_q;

    assign full_o  = (count_q == uart_cfg_pkg::fifo_cnt_t'(uart_cfg_pkg::FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign data_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // the pointers wrap on their own since the depth is a power of two
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        push_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pop_i |-> !empty_o);

endmodule

//--- design/uart_regs.sv
// UART register block
`timescale 1ns/100ps

module uart_regs (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  uart_bus_pkg::apb_req_t apb_req_i,
    input  logic                   tx_full_i,
    input  logic                   tx_empty_i,
    input  logic                   rx_empty_i,
    input  logic                   rx_full_i,
    input  uart_cfg_pkg::byte_t    rx_data_i,
    input  logic                   rx_valid_i,
    output uart_bus_pkg::apb_rsp_t apb_rsp_o,
    output logic                   tx_push_o,
    output uart_cfg_pkg::byte_t    tx_data_o,
    output logic                   rx_pop_o
);

    logic                access;
    logic                is_data;
    logic                is_status;
    logic                err;
    logic                overrun_q;
    uart_bus_pkg::word_t status;

    assign access    = apb_req_i.psel && apb_req_i.penable;
    assign is_data   = (apb_req_i.paddr == uart_bus_pkg::ADDR_DATA);
    assign is_status = (apb_req_i.paddr == uart_bus_pkg::ADDR_STATUS);

    // an unmapped address, a write into a full TX FIFO or a read of an empty RX FIFO
    assign err = access && (!(is_data || is_status) ||
                            (is_data && apb_req_i.pwrite && tx_full_i) ||
                            (is_data && !apb_req_i.pwrite && rx_empty_i));

    assign tx_push_o = access && is_data && apb_req_i.pwrite && !err;
    assign tx_data_o = apb_req_i.pwdata[7:0];
    assign rx_pop_o  = access && is_data && !apb_req_i.pwrite && !err;

    always_comb begin
        status                              = '0;
        status[uart_cfg_pkg::ST_TX_FULL]    = tx_full_i;
        status[uart_cfg_pkg::ST_TX_EMPTY]   = tx_empty_i;
        status[uart_cfg_pkg::ST_RX_EMPTY]   = rx_empty_i;
        status[uart_cfg_pkg::ST_RX_FULL]    = rx_full_i;
        status[uart_cfg_pkg::ST_RX_OVERRUN] = overrun_q;
    end

    always_comb begin
        apb_rsp_o.prdata  = '0;
        apb_rsp_o.pready  = 1'b1;
        apb_rsp_o.pslverr = err;
        if (!apb_req_i.pwrite && is_data) begin
            apb_rsp_o.prdata = uart_bus_pkg::word_t'(rx_data_i);
        end else if (!apb_req_i.pwrite && is_status) begin
            apb_rsp_o.prdata = status;
        end
    end

    // a STATUS read clears the flag, but a byte lost in the same cycle keeps it set
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            overrun_q <= 1'b0;
        end else if (rx_valid_i && rx_full_i) begin
            overrun_q <= 1'b1;
        end else if (access && is_status && !apb_req_i.pwrite) begin
            overrun_q <= 1'b0;
        end
    end

    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        tx_push_o |-> !tx_full_i);

endmodule

//--- design/uart_apb_bridge.sv
// Request to APB bridge
`timescale 1ns/100ps

module uart_apb_bridge (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_valid_i,
    input  uart_bus_pkg::bus_req_t req_i,
    input  uart_bus_pkg::apb_rsp_t apb_rsp_i,
    output uart_bus_pkg::apb_req_t apb_req_o,
    output logic                   rsp_valid_o,
    output uart_bus_pkg::word_t    rsp_rdata_o,
    output logic                   rsp_err_o
);

    uart_cfg_pkg::bridge_state_e state_q;
    uart_bus_pkg::bus_req_t      req_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= uart_cfg_pkg::BR_IDLE;
        end else begin
            case (state_q)
                uart_cfg_pkg::BR_IDLE: begin
                    if (req_valid_i) begin
                        state_q <= uart_cfg_pkg::BR_SETUP;
                    end
                end
                uart_cfg_pkg::BR_SETUP:  state_q <= uart_cfg_pkg::BR_ACCESS;
                uart_cfg_pkg::BR_ACCESS: begin
                    // the slave may stretch the access phase with pready low
                    if (apb_rsp_i.pready) begin
                        state_q <= uart_cfg_pkg::BR_RESP;
                    end
                end
                default: state_q <= uart_cfg_pkg::BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == uart_cfg_pkg::BR_IDLE && req_valid_i) begin
            req_q <= req_i;
        end
        if (state_q == uart_cfg_pkg::BR_ACCESS && apb_rsp_i.pready) begin
            rsp_rdata_o <= apb_rsp_i.prdata;
            rsp_err_o   <= apb_rsp_i.pslverr;
        end
    end

    always_comb begin
        apb_req_o.psel    = (state_q == uart_cfg_pkg::BR_SETUP) ||
                            (state_q == uart_cfg_pkg::BR_ACCESS);
        apb_req_o.penable = (state_q == uart_cfg_pkg::BR_ACCESS);
        apb_req_o.pwrite  = req_q.write;
        apb_req_o.paddr   = req_q.addr;
        apb_req_o.pwdata  = req_q.wdata;
    end

    assign rsp_valid_o = (state_q == uart_cfg_pkg::BR_RESP);

    // setup is always followed by access with the same address
    a_setup_to_access: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        apb_req_o.psel && !apb_req_o.penable
        |=> apb_req_o.psel && apb_req_o.penable && $stable(apb_req_o.paddr));

    // the requester must wait for the response before the next strobe
    a_strobe_when_idle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> state_q == uart_cfg_pkg::BR_IDLE);

endmodule

//--- design/uart_cfg_pkg.sv
// UART configuration and states
package uart_cfg_pkg;

    typedef logic [7:0] byte_t;

    // fixed baud rate, no divider register
    localparam int CLKS_PER_BIT = 8;

    localparam int FIFO_DEPTH = 4;
    typedef logic [2:0] fifo_cnt_t;

    // status register bit positions
    localparam int ST_TX_FULL    = 0;
    localparam int ST_TX_EMPTY   = 1;
    localparam int ST_RX_EMPTY   = 2;
    localparam int ST_RX_FULL    = 3;
    localparam int ST_RX_OVERRUN = 4;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
    typedef enum logic [1:0] {BR_IDLE, BR_SETUP, BR_ACCESS, BR_RESP} bridge_state_e;

endpackage

//--- design/uart_bus_pkg.sv
// UART register bus types
package uart_bus_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // byte offsets inside the UART window, anything else is unmapped
    localparam reg_addr_t ADDR_DATA   = 4'h0;
    localparam reg_addr_t ADDR_STATUS = 4'h4;

    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        word_t     wdata;
    } bus_req_t;

    typedef struct packed {
        logic      psel;
        logic      penable;
        logic      pwrite;
        reg_addr_t paddr;
        word_t     pwdata;
    } apb_req_t;

    typedef struct packed {
        word_t prdata;
        logic  pready;
        logic  pslverr;
    } apb_rsp_t;

endpackage
